// File: sources.f
hw/fe_cfg_pkg.sv
hw/isa_pkg.sv
hw/fetch_stage.sv
hw/imem.sv
hw/instr_queue.sv
hw/frontend_top.sv
dv/tb_clkgen.sv
dv/frontend_tb.sv

// File: dv/frontend_tb.sv
module frontend_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 20;
    localparam int AW            = fe_cfg_pkg::IMEM_AW;
    localparam int MEM_WORDS     = 2 ** AW;
    localparam int RUN_CYCLES    = 4000;
    localparam int STEADY_CYCLES = 500;
    localparam int MIN_CHECKED   = 1000;
    localparam int WATCHDOG_NS   =
        2 * CLK_PERIOD * ((MEM_WORDS + RUN_CYCLES) * fe_cfg_pkg::LAT_MAX);
    localparam logic [31:0] SEED = 32'h684f_e3c3;

    logic                           clk;
    logic                           rst;
    logic                           flush;
    logic [fe_cfg_pkg::RW-1:0]      exec_pc;
    logic                           wr_en;
    logic [AW-1:0]                  wr_addr;
    logic [fe_cfg_pkg::I_SIZE-1:0]  wr_data;
    logic                           ready;
    logic                           o_valid;
    logic [fe_cfg_pkg::I_SIZE-1:0]  o_instr;
    logic                           o_pred;
    logic [fe_cfg_pkg::RW-1:0]      o_pc;

    // copy of the program as loaded into imem
    logic [fe_cfg_pkg::I_SIZE-1:0]  prog [MEM_WORDS];

    // model state
    logic [fe_cfg_pkg::RW-1:0]      exp_pc;
    logic                           rst_seen;
    int                             checked;
    int                             n_jump;
    int                             n_back;
    int                             n_fwd;
    int                             n_stall;
    int                             flush_gap;
    int                             stall_left;
    logic                           run_ok;

    tb_clkgen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) u_clkgen (
        .o_clk (clk),
        .o_rst (rst)
    );

    frontend_top i_dut (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_flush   (flush),
        .i_exec_pc (exec_pc),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .o_valid   (o_valid),
        .o_instr   (o_instr),
        .o_pred    (o_pred),
        .o_pc      (o_pc),
        .i_ready   (ready)
    );

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    // weighted opcode mix with immediates mostly inside the memory so loops occur
    function automatic logic [fe_cfg_pkg::I_SIZE-1:0] make_word();
        logic [fe_cfg_pkg::I_SIZE-1:0] w;
        int unsigned                   pick;
        int unsigned                   other;
        w    = $urandom();
        pick = $urandom_range(0, 99);
        if (pick < 10) begin
            w[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB]   = isa_pkg::OPC_JCOND;
            w[isa_pkg::COND_MSB:isa_pkg::COND_LSB] = isa_pkg::COND_ALWAYS;
        end else if (pick < 20) begin
            w[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB]   = isa_pkg::OPC_JCOND;
            w[isa_pkg::COND_MSB:isa_pkg::COND_LSB] = 4'($urandom_range(1, 15));
        end else if (pick < 25) begin
            w[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB] = isa_pkg::OPC_JMP;
        end else begin
            // any opcode except the two jumps
            other = $urandom_range(0, 125);
            if (other >= 14) begin
                other = other + 2;
            end
            w[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB] = 7'(other);
        end
        if ($urandom_range(0, 3) == 0) begin
            w[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB] = 16'($urandom());
        end else begin
            w[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB] = 16'($urandom_range(0, MEM_WORDS - 1));
        end
        return w;
    endfunction

    function automatic logic predict_taken(input logic [fe_cfg_pkg::I_SIZE-1:0] word,
                                           input logic [fe_cfg_pkg::RW-1:0] pc);
        logic [6:0]  opc;
        logic [3:0]  cond;
        logic [15:0] imm;
        opc  = word[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB];
        cond = word[isa_pkg::COND_MSB:isa_pkg::COND_LSB];
        imm  = word[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];
        if (opc == isa_pkg::OPC_JMP) begin
            return 1'b1;
        end
        if (opc == isa_pkg::OPC_JCOND) begin
            // conditional only when the target is behind the pc
            return (cond == isa_pkg::COND_ALWAYS) || (imm < pc);
        end
        return 1'b0;
    endfunction

    task automatic check_output();
        logic [fe_cfg_pkg::I_SIZE-1:0] exp_word;
        logic                          exp_pred;
        exp_word = prog[exp_pc[AW-1:0]];
        exp_pred = predict_taken(exp_word, exp_pc);
        assert (o_pc === exp_pc) else
            stop_with_error($sformatf("[FAIL] %0t o_pc expected %h, got %h",
                                      $time, exp_pc, o_pc));
        assert (o_instr === exp_word) else
            stop_with_error($sformatf("[FAIL] %0t pc %h: o_instr expected %h, got %h",
                                      $time, exp_pc, exp_word, o_instr));
        assert (o_pred === exp_pred) else
            stop_with_error($sformatf("[FAIL] %0t pc %h: o_pred expected %b, got %b",
                                      $time, exp_pc, exp_pred, o_pred));
        if (exp_word[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB] == isa_pkg::OPC_JMP ||
            (exp_word[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB] == isa_pkg::OPC_JCOND &&
             exp_word[isa_pkg::COND_MSB:isa_pkg::COND_LSB] == isa_pkg::COND_ALWAYS)) begin
            n_jump++;
        end else if (exp_word[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB] == isa_pkg::OPC_JCOND) begin
            if (exp_pred) begin
                n_back++;
            end else begin
                n_fwd++;
            end
        end
        exp_pc = exp_pred ? exp_word[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB] : exp_pc + 1'b1;
        checked++;
    endtask

    // outputs are sampled on the rising edge while inputs settle on the falling edge
    always @(posedge clk) begin
        if (rst_seen && (rst || flush)) begin
            assert (o_valid === 1'b0) else
                stop_with_error($sformatf("[FAIL] %0t o_valid high during reset or flush",
                                          $time));
        end
        if (rst) begin
            rst_seen = 1'b1;
            exp_pc   = '0;
        end else if (flush) begin
            exp_pc = exec_pc;
        end else if (o_valid === 1'b1) begin
            if (ready) begin
                check_output();
            end else begin
                n_stall++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("the run did not finish before the watchdog limit");
    end

    initial begin
        void'($urandom(SEED));
        flush             = 1'b1;
        exec_pc           = '0;
        wr_en             = 1'b0;
        wr_addr           = '0;
        wr_data           = '0;
        ready             = 1'b0;
        rst_seen          = 1'b0;
        exp_pc            = '0;
        checked           = 0;
        n_jump            = 0;
        n_back            = 0;
        n_fwd             = 0;
        n_stall           = 0;
        stall_left        = 0;
        flush_gap         = $urandom_range(100, 200);
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = make_word();
        end

        wait (rst == 1'b0);
        // program load while fetch is held in flush
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = AW'(i);
            wr_data = prog[i];
        end
        @(negedge clk);
        wr_en   = 1'b0;
        exec_pc = '0;
        @(negedge clk);
        flush = 1'b0;
        ready = 1'b1;

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(negedge clk);
            if (cyc >= STEADY_CYCLES) begin
                flush = 1'b0;
                if (flush_gap == 0) begin
                    flush     = 1'b1;
                    exec_pc   = 16'($urandom_range(0, 2 * MEM_WORDS - 1));
                    flush_gap = $urandom_range(100, 200);
                end else begin
                    flush_gap--;
                end
                // long stalls fill the queue and the hold buffer
                if (stall_left > 0) begin
                    ready = 1'b0;
                    stall_left--;
                end else if ($urandom_range(0, 119) == 0) begin
                    ready      = 1'b0;
                    stall_left = $urandom_range(4, 32);
                end else begin
                    ready = ($urandom_range(0, 3) != 0);
                end
            end
        end
        @(negedge clk);
        flush = 1'b0;

        $display("checked %0d words: %0d jumps, %0d backward taken, %0d forward fall-through",
                 checked, n_jump, n_back, n_fwd);
        $display("%0d cycles with output held by back-pressure", n_stall);
        run_ok = 1'b1;
        assert (checked >= MIN_CHECKED) else begin
            $display("too few words were checked: %0d, at least %0d needed",
                     checked, MIN_CHECKED);
            run_ok = 1'b0;
        end
        assert (n_jump > 0 && n_back > 0 && n_fwd > 0) else begin
            $display("not every kind of branch word was checked");
            run_ok = 1'b0;
        end
        assert (n_stall > 0) else begin
            $display("the output was never held by back-pressure");
            run_ok = 1'b0;
        end
        if (run_ok) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "run ended with a failed end-of-run check");
        end
    end

endmodule

// File: dv/tb_clkgen.sv
module tb_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // reset spans the first rising edges and drops on a falling edge
    initial begin
        o_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

// File: hw/frontend_top.sv
module frontend_top (
    input  logic                           i_clk,
    input  logic                           i_rst,

    // redirect from the execute side
    input  logic                           i_flush,
    input  logic [fe_cfg_pkg::RW-1:0]      i_exec_pc,

    // program load port
    input  logic                           i_wr_en,
    input  logic [fe_cfg_pkg::IMEM_AW-1:0] i_wr_addr,
    input  logic [fe_cfg_pkg::I_SIZE-1:0]  i_wr_data,

    // stream toward decode
    output logic                           o_valid,
    output logic [fe_cfg_pkg::I_SIZE-1:0]  o_instr,
    output logic                           o_pred,
    output logic [fe_cfg_pkg::RW-1:0]      o_pc,
    input  logic                           i_ready
);

    // fetch to memory
    logic [fe_cfg_pkg::RW-1:0]     req_addr;
    logic                          req_active;
    logic [fe_cfg_pkg::I_SIZE-1:0] req_data;
    logic                          req_data_valid;

    // fetch to queue
    logic                          next_ready;
    logic                          submit;
    logic [fe_cfg_pkg::I_SIZE-1:0] fetch_instr;
    logic                          fetch_pred;
    logic [fe_cfg_pkg::RW-1:0]     fetch_pc;

    fetch_stage u_fetch (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .o_req_addr       (req_addr),
        .o_req_active     (req_active),
        .i_req_data       (req_data),
        .i_req_data_valid (req_data_valid),
        .i_next_ready     (next_ready),
        .o_submit         (submit),
        .i_flush          (i_flush),
        .i_exec_pc        (i_exec_pc),
        .o_instr          (fetch_instr),
        .o_jmp_predict    (fetch_pred),
        .o_pc             (fetch_pc)
    );

    imem u_imem (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req_active (req_active),
        .i_req_addr   (req_addr),
        .o_data       (req_data),
        .o_data_valid (req_data_valid),
        .i_wr_en      (i_wr_en),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data)
    );

    instr_queue u_queue (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_flush       (i_flush),
        .i_push        (submit),
        .i_instr       (fetch_instr),
        .i_pred        (fetch_pred),
        .i_pc          (fetch_pc),
        .o_ready_early (next_ready),
        .o_valid       (o_valid),
        .o_instr       (o_instr),
        .o_pred        (o_pred),
        .o_pc          (o_pc),
        .i_ready       (i_ready)
    );

endmodule

// File: hw/instr_queue.sv
module instr_queue (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_flush,

    input  logic                          i_push,
    input  logic [fe_cfg_pkg::I_SIZE-1:0] i_instr,
    input  logic                          i_pred,
    input  logic [fe_cfg_pkg::RW-1:0]     i_pc,
    output logic                          o_ready_early,

    output logic                          o_valid,
    output logic [fe_cfg_pkg::I_SIZE-1:0] o_instr,
    output logic                          o_pred,
    output logic [fe_cfg_pkg::RW-1:0]     o_pc,
    input  logic                          i_ready
);

    localparam int PTR_W = $clog2(fe_cfg_pkg::Q_DEPTH);
    localparam int CNT_W = $clog2(fe_cfg_pkg::Q_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(fe_cfg_pkg::Q_DEPTH);

    logic [fe_cfg_pkg::I_SIZE-1:0] instr_mem [fe_cfg_pkg::Q_DEPTH];
    logic                          pred_mem  [fe_cfg_pkg::Q_DEPTH];
    logic [fe_cfg_pkg::RW-1:0]     pc_mem    [fe_cfg_pkg::Q_DEPTH];

    // pointers wrap by overflow since the depth is a power of two
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !i_flush;
    assign do_pop  = o_valid && i_ready;

    // nothing leaves while the queue is being flushed
    assign o_valid = (count != '0) && !i_flush;
    assign o_instr = instr_mem[rd_ptr];
    assign o_pred  = pred_mem[rd_ptr];
    assign o_pc    = pc_mem[rd_ptr];

    // leaves room for the word in flight plus the one the ready allows
    assign o_ready_early = i_push ? (count < FULL - 1'b1) : (count < FULL);

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            instr_mem[wr_ptr] <= i_instr;
            pred_mem[wr_ptr]  <= i_pred;
            pc_mem[wr_ptr]    <= i_pc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/imem.sv
module imem (
    input  logic                          i_clk,
    input  logic                          i_rst,

    input  logic                          i_req_active,
    input  logic [fe_cfg_pkg::RW-1:0]     i_req_addr,
    output logic [fe_cfg_pkg::I_SIZE-1:0] o_data,
    output logic                          o_data_valid,

    input  logic                          i_wr_en,
    input  logic [fe_cfg_pkg::IMEM_AW-1:0] i_wr_addr,
    input  logic [fe_cfg_pkg::I_SIZE-1:0] i_wr_data
);

    localparam int DEPTH = 2 ** fe_cfg_pkg::IMEM_AW;
    localparam int CNT_W = $clog2(fe_cfg_pkg::LAT_MAX);

    logic [fe_cfg_pkg::I_SIZE-1:0]  mem [DEPTH];

    logic [fe_cfg_pkg::IMEM_AW-1:0] addr_q;
    logic                           busy;
    // cycles left before the word is returned
    logic [CNT_W-1:0]               wait_cnt;
    logic [7:0]                     lfsr;
    logic [CNT_W-1:0]               lat_draw;
    logic                           accept;

    // new requests are taken only when nothing is in flight
    assign accept   = i_req_active && !busy;
    assign lat_draw = CNT_W'(lfsr % fe_cfg_pkg::LAT_MAX);

    // word is presented in the last cycle of the wait
    assign o_data_valid = busy && (wait_cnt == '0);
    assign o_data       = mem[addr_q];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1, steps every cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            lfsr <= 8'h5a;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else if (accept) begin
            busy     <= 1'b1;
            wait_cnt <= lat_draw;
        end else if (busy) begin
            if (wait_cnt == '0) begin
                busy <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // upper pc bits wrap onto the same words
    always_ff @(posedge i_clk) begin
        if (accept) begin
            addr_q <= i_req_addr[fe_cfg_pkg::IMEM_AW-1:0];
        end
    end

endmodule

// File: hw/fetch_stage.sv
module fetch_stage (
    input  logic                          i_clk,
    input  logic                          i_rst,

    output logic [fe_cfg_pkg::RW-1:0]     o_req_addr,
    output logic                          o_req_active,
    input  logic [fe_cfg_pkg::I_SIZE-1:0] i_req_data,
    input  logic                          i_req_data_valid,

    input  logic                          i_next_ready,
    output logic                          o_submit,
    input  logic                          i_flush,
    input  logic [fe_cfg_pkg::RW-1:0]     i_exec_pc,

    output logic [fe_cfg_pkg::I_SIZE-1:0] o_instr,
    output logic                          o_jmp_predict,
    output logic [fe_cfg_pkg::RW-1:0]     o_pc
);

    // word parked while the queue cannot take it
    logic [fe_cfg_pkg::I_SIZE-1:0] hold_instr;
    logic                          hold_valid;

    // pc of o_instr and the address predicted to follow it
    logic [fe_cfg_pkg::RW-1:0]     fetch_pc;
    logic [fe_cfg_pkg::RW-1:0]     next_fetch_pc;
    logic                          next_branch_pred;

    // set when a read issued before a flush is still in the memory
    logic                          invalidate_request;

    // branch view of the last word
    logic [isa_pkg::OPC_MSB-isa_pkg::OPC_LSB:0]   instr_opc;
    logic [isa_pkg::COND_MSB-isa_pkg::COND_LSB:0] instr_cond;
    logic [fe_cfg_pkg::RW-1:0]                    instr_imm;

    assign instr_opc  = o_instr[isa_pkg::OPC_MSB:isa_pkg::OPC_LSB];
    assign instr_cond = o_instr[isa_pkg::COND_MSB:isa_pkg::COND_LSB];
    assign instr_imm  = o_instr[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];

    // the request address follows the prediction without a register stage
    assign o_req_addr    = next_fetch_pc;
    assign o_jmp_predict = next_branch_pred;
    assign o_pc          = fetch_pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            // all ones, so the first prediction lands on pc 0
            fetch_pc           <= '1;
            o_instr            <= '0;
            o_submit           <= 1'b0;
            o_req_active       <= 1'b0;
            hold_valid         <= 1'b0;
            invalidate_request <= 1'b0;
        end else if (i_flush) begin
            o_submit   <= 1'b0;
            hold_valid <= 1'b0;
            // one below the target, a cleared word then predicts +1
            fetch_pc   <= i_exec_pc - 1'b1;
            o_instr    <= '0;
            // an active request may already be in the memory
            invalidate_request <= o_req_active;
        end else if (i_req_data_valid && invalidate_request) begin
            // stale word from before the flush, drop it and fetch again
            invalidate_request <= 1'b0;
            o_req_active       <= 1'b1;
            o_submit           <= 1'b0;
        end else if (i_req_data_valid && i_next_ready) begin
            o_instr      <= i_req_data;
            fetch_pc     <= next_fetch_pc;
            o_submit     <= 1'b1;
            o_req_active <= 1'b1;
        end else if (i_req_data_valid) begin
            // queue is full, park the word and stop reading
            hold_instr   <= i_req_data;
            hold_valid   <= 1'b1;
            o_req_active <= 1'b0;
            o_submit     <= 1'b0;
        end else if (hold_valid && i_next_ready) begin
            o_instr      <= hold_instr;
            fetch_pc     <= next_fetch_pc;
            o_submit     <= 1'b1;
            hold_valid   <= 1'b0;
            o_req_active <= 1'b1;
        end else if (!hold_valid) begin
            o_req_active <= 1'b1;
            o_submit     <= 1'b0;
        end
    end

    // static prediction from the last word and its pc
    always_comb begin
        next_fetch_pc    = fetch_pc + 1'b1;
        next_branch_pred = 1'b0;
        if (instr_opc == isa_pkg::OPC_JCOND) begin
            // conditional jumps are taken only when they go backward
            if (instr_cond == isa_pkg::COND_ALWAYS || instr_imm < fetch_pc) begin
                next_fetch_pc    = instr_imm;
                next_branch_pred = 1'b1;
            end
        end else if (instr_opc == isa_pkg::OPC_JMP) begin
            next_fetch_pc    = instr_imm;
            next_branch_pred = 1'b1;
        end
    end

endmodule

// File: hw/isa_pkg.sv
package isa_pkg;

    // opcode field
    localparam int OPC_LSB = 0;
    localparam int OPC_MSB = 6;

    // branch condition field
    localparam int COND_LSB = 7;
    localparam int COND_MSB = 10;

    // immediate, also the absolute jump target
    localparam int IMM_LSB = 16;
    localparam int IMM_MSB = 31;

    // jump on condition, or always when the condition is zero
    localparam logic [OPC_MSB-OPC_LSB:0] OPC_JCOND = 7'h0e;

    // jump that ignores the condition field
    localparam logic [OPC_MSB-OPC_LSB:0] OPC_JMP = 7'h0f;

    localparam logic [COND_MSB-COND_LSB:0] COND_ALWAYS = 4'h0;

endpackage

// File: hw/fe_cfg_pkg.sv
package fe_cfg_pkg;

    // register and pc width
    localparam int RW = 16;

    // instruction word width
    localparam int I_SIZE = 32;

    // instruction memory address bits, 256 words
    // pc bits above these are not decoded
    localparam int IMEM_AW = 8;

    // slowest read, the fastest takes a single cycle
    localparam int LAT_MAX = 4;

    // fetch to decode queue entries, kept a power of two
    localparam int Q_DEPTH = 4;

endpackage
